// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = ping_rx_tb
FILELIST = compile.f
BUILD = obj_dir
LOG = sim.log
SIM_ARGS = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== compile.f ====
+incdir+hdl
hdl/ping_pkg.sv
hdl/ping_cfg_regs.sv
hdl/ping_frame_matcher.sv
hdl/ping_rx_stats.sv
hdl/ping_rx_top.sv
dv/ping_rx_assert.sv
dv/ping_rx_tb.sv

// ==== dv/ping_rx_assert.sv ====
/* Concurrent checks on the Wishbone handshake and the frame verdicts of the
   ping receiver, attached to ping_rx_top by the bind below. */
`timescale 1ns/1ns

module ping_rx_assert
	import ping_pkg::*;
(
	input logic clk_rx,
	input logic rst_rx,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp,
	input logic frame_ok,
	input logic frame_bad,
	input logic [15:0] ping_id
);
	int assert_errors = 0; // read by the testbench at the end.

	ack_in_access: assert property (@(posedge clk_rx) disable iff (rst_rx)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
	else begin
		$error("ack high outside a bus access");
		assert_errors++;
	end

	ack_one_cycle: assert property (@(posedge clk_rx) disable iff (rst_rx)
		wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		$error("ack high for two cycles");
		assert_errors++;
	end

	one_verdict: assert property (@(posedge clk_rx) disable iff (rst_rx)
		!(frame_ok && frame_bad))
	else begin
		$error("frame_ok and frame_bad high together");
		assert_errors++;
	end

	// ping id moves only with a match.
	id_on_match: assert property (@(posedge clk_rx) disable iff (rst_rx)
		(ping_id != $past(ping_id)) |-> frame_ok)
	else begin
		$error("ping_id changed without frame_ok");
		assert_errors++;
	end

endmodule

bind ping_rx_top ping_rx_assert ping_rx_assert_inst (
	.clk_rx(clk_rx),
	.rst_rx(rst_rx),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.frame_ok(frame_ok),
	.frame_bad(frame_bad),
	.ping_id(ping_id)
);

// ==== dv/ping_rx_cases.txt ====
# W addr data, R addr expected, F length corrupt_index seq; all values hex
# corrupt_index FF leaves the frame intact, FE sends the other echo type
R 8 FFFF
R 9 0
R A 0
W 0 22334455
W 1 0011
W 2 CCDDEEFF
W 3 02AA
W 4 C0A80A01
W 5 C0A80A02
W 6 1234BEEF
W 7 1
R 0 22334455
R 1 0011
R 2 CCDDEEFF
R 3 02AA
R 4 C0A80A01
R 5 C0A80A02
R 6 1234BEEF
R 7 1
R C 0
F 2A FF 0101
R 8 0101
F 2A 22 0202
R A 1
F 2A 5 0303
R A 2
F 2A 24 0404
R 8 0404
F 28 FF 0505
R A 3
F 29 FF 0606
R A 4
W 7 0
F 2A FE 0707
R A 5
F 2A FF 0808
R 9 3
F 2A FF 0909
F 40 1C 0A0A
F 2A FF 0B0B
F 30 FF 0C0C
F 2A 25 0D0D
R 9 7
R A 6
R 8 0D0D

// ==== dv/ping_rx_tb.sv ====
/* Testbench for the ping receiver. Reads register and frame cases from a file,
   drives them into the DUT and checks the responses against its own header model. */
`timescale 1ns/1ns
`include "ping_config.svh"

module ping_rx_tb
	import ping_pkg::*;
();

	logic clk_rx;
	logic rst_rx;
	ping_beat_t rx;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [15:0] ping_id;

	logic [7:0] kind_q[$]; // case line kind.
	logic [31:0] arg1_q[$];
	logic [31:0] arg2_q[$];
	logic [31:0] arg3_q[$];
	logic [31:0] exp_ok_q[$]; // predicted verdicts of frames in flight.
	logic [31:0] exp_id_q[$];
	logic [31:0] got_ok_q[$]; // verdicts seen on the DUT.
	logic [31:0] got_id_q[$];
	logic [47:0] m_mac_dst;
	logic [47:0] m_mac_src;
	logic [31:0] m_ip_src;
	logic [31:0] m_ip_dst;
	logic [15:0] m_frame_id;
	logic [15:0] m_log_id;
	logic m_reply;
	logic [15:0] m_ping_id;
	logic [15:0] m_matched;
	logic [15:0] m_rejected;
	int seed = 38;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0; // set once the cases are known.

	ping_rx_top ping_rx_top_inst (
		.clk_rx(clk_rx), .rst_rx(rst_rx), .rx(rx),
		.wb_req(wb_req), .wb_rsp(wb_rsp), .ping_id(ping_id)
	);

	initial begin
		clk_rx = 1'b0;
		forever #20 clk_rx = ~clk_rx;
	end

	always @(posedge clk_rx) begin
		cycles <= cycles + 1;
	end

	// records each verdict together with the ping_id it leaves behind.
	always @(posedge clk_rx) begin
		if (!rst_rx && (ping_rx_top_inst.frame_ok || ping_rx_top_inst.frame_bad)) begin
			got_ok_q.push_back({31'd0, ping_rx_top_inst.frame_ok});
			got_id_q.push_back({16'h0000, ping_id});
		end
	end

	initial begin
		wait (limit > 0);
		while (cycles < limit) @(posedge clk_rx);
		$display("run stopped by timeout after %0d cycles", cycles);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Checks failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic wb_access(input logic we, input logic [31:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		wb_req_t req;
		int n;
		logic got;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = adr[3:0];
		req.dat_w = wdata;
		n = 0;
		got = 1'b0;
		rdata = 32'h0;
		@(posedge clk_rx);
		wb_req <= req;
		while (!got && n < 16) begin
			@(posedge clk_rx);
			n++;
			if (wb_rsp.ack) begin
				got = 1'b1;
				rdata = wb_rsp.dat_r;
			end
		end
		wb_req <= '0; // bus released on the ack edge.
		if (!got) begin
			$display("no Wishbone ack for word %0h", adr);
			errors++;
		end
	endtask

	task automatic model_write(input logic [31:0] adr, input logic [31:0] data);
		case (adr[3:0])
			`PING_REG_MAC_DST_LO: m_mac_dst[31:0] = data;
			`PING_REG_MAC_DST_HI: m_mac_dst[47:32] = data[15:0];
			`PING_REG_MAC_SRC_LO: m_mac_src[31:0] = data;
			`PING_REG_MAC_SRC_HI: m_mac_src[47:32] = data[15:0];
			`PING_REG_IP_SRC: m_ip_src = data;
			`PING_REG_IP_DST: m_ip_dst = data;
			`PING_REG_IDS: {m_frame_id, m_log_id} = data;
			`PING_REG_MODE: m_reply = data[0];
			default: ; // status and unmapped words.
		endcase
	endtask

	// byte idx of the ethernet, ipv4 and icmp echo header in wire order.
	function automatic logic [7:0] hdr_byte(input int idx, input logic other_type);
		logic [319:0] h;
		logic [7:0] icmp_type;
		icmp_type = (m_reply ^ other_type) ? 8'h00 : 8'h08;
		h = {m_mac_dst, m_mac_src, 16'h0800, 16'h4500, 16'h001C, m_frame_id, 16'h4000,
			8'h40, 8'h01, 16'h0000, m_ip_src, m_ip_dst, icmp_type, 8'h00, 16'h0000, m_log_id};
		return h[319 - 8 * idx -: 8];
	endfunction

	function automatic logic is_csum(input int idx);
		return idx == 24 || idx == 25 || idx == 36 || idx == 37;
	endfunction

	task automatic send_frame(input logic [31:0] len, input logic [31:0] corrupt,
		input logic [31:0] seq);
		logic [7:0] fb[256];
		ping_beat_t beat;
		logic bad;
		int r;
		int j;
		for (j = 0; j < len; j++) begin
			if (j < 40 && is_csum(j)) begin
				r = $random(seed);
				fb[j] = r[7:0]; // checksums are never compared.
			end else if (j < 40) begin
				fb[j] = hdr_byte(j, corrupt == 32'hFE);
			end else if (j == 40) begin
				fb[j] = seq[15:8];
			end else if (j == 41) begin
				fb[j] = seq[7:0];
			end else begin
				fb[j] = 8'hA5 ^ j[7:0]; // padding.
			end
		end
		bad = (corrupt == 32'hFE) || (corrupt < 40 && corrupt < len && !is_csum(corrupt));
		if (corrupt < len && corrupt != 32'hFE) begin
			fb[corrupt] = ~fb[corrupt];
		end
		if (len >= 42 && !bad) begin
			m_ping_id = {fb[40], fb[41]};
			m_matched++;
			exp_ok_q.push_back(32'd1);
		end else begin
			m_rejected++;
			exp_ok_q.push_back(32'd0);
		end
		exp_id_q.push_back({16'h0000, m_ping_id});
		for (j = 0; j < len; j++) begin
			beat.data = fb[j];
			beat.last = (j == len - 1);
			beat.valid = 1'b1;
			@(posedge clk_rx);
			rx <= beat;
		end
	endtask

	// idle the stream, collect the verdicts of the burst and compare counters.
	task automatic finish_burst();
		int n;
		logic [31:0] rd;
		@(posedge clk_rx);
		rx <= '0;
		n = 0;
		while (got_ok_q.size() < exp_ok_q.size() && n < 20) begin
			@(posedge clk_rx);
			n++;
		end
		if (got_ok_q.size() != exp_ok_q.size()) begin
			$display("saw %0d verdicts for %0d frames", got_ok_q.size(), exp_ok_q.size());
			errors++;
		end else begin
			foreach (exp_ok_q[k]) begin
				check_value("frame_ok", got_ok_q[k], exp_ok_q[k]);
				check_value("ping_id", got_id_q[k], exp_id_q[k]);
			end
		end
		got_ok_q.delete();
		got_id_q.delete();
		exp_ok_q.delete();
		exp_id_q.delete();
		check_value("ping_id", {16'h0000, ping_id}, {16'h0000, m_ping_id});
		wb_access(1'b0, 32'd9, 32'd0, rd);
		check_value("matched_count", rd, {16'h0000, m_matched});
		wb_access(1'b0, 32'd10, 32'd0, rd);
		check_value("rejected_count", rd, {16'h0000, m_rejected});
	endtask

	initial begin
		int fd;
		int asrt;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] rd;
		logic in_burst;
		rst_rx = 1'b1;
		rx = '0;
		wb_req = '0;
		{m_mac_dst, m_mac_src, m_ip_src, m_ip_dst, m_frame_id, m_log_id, m_reply} = '0;
		m_ping_id = 16'hFFFF;
		m_matched = 16'd0;
		m_rejected = 16'd0;
		in_burst = 1'b0;
		fd = $fopen("dv/ping_rx_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file");
			errors++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				c = 32'd0;
				if (line.len() > 2 && line.getc(0) != "#" &&
					$sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c) >= 2) begin
					kind_q.push_back(line.getc(0));
					arg1_q.push_back(a);
					arg2_q.push_back(b);
					arg3_q.push_back(c);
				end
			end
			$fclose(fd);
		end
		limit = kind_q.size() * 100 + 50;
		repeat (10) @(posedge clk_rx);
		rst_rx <= 1'b0;
		foreach (kind_q[i]) begin
			if (in_burst && kind_q[i] != "F") begin
				finish_burst();
				in_burst = 1'b0;
			end
			case (kind_q[i])
				"W": begin
					wb_access(1'b1, arg1_q[i], arg2_q[i], rd);
					model_write(arg1_q[i], arg2_q[i]);
				end
				"R": begin
					wb_access(1'b0, arg1_q[i], 32'd0, rd);
					check_value($sformatf("dat_r word %0h", arg1_q[i]), rd, arg2_q[i]);
				end
				"F": begin
					send_frame(arg1_q[i], arg2_q[i], arg3_q[i]);
					in_burst = 1'b1; // frames on consecutive lines go back to back.
				end
				default: begin
					$display("unknown case kind %c", kind_q[i]);
					errors++;
				end
			endcase
		end
		if (in_burst) begin
			finish_burst();
		end
		asrt = ping_rx_top_inst.ping_rx_assert_inst.assert_errors;
		$display("checks %0d, errors %0d, assertion errors %0d", checks, errors, asrt);
		if (errors == 0 && asrt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== hdl/ping_cfg_regs.sv ====
/* Wishbone classic slave for the ping receiver. Holds the expected addresses,
   identifiers and mode, and reads back the latest ping id and frame counters. */
`timescale 1ns/1ns
`include "ping_config.svh"

module ping_cfg_regs
	import ping_pkg::*;
(
	input logic clk_rx,
	input logic rst_rx,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	input logic [15:0] ping_id,
	input logic [15:0] matched_count,
	input logic [15:0] rejected_count,
	output ping_cfg_t cfg
);
	logic ack;
	logic [31:0] dat_r;
	logic access; // first cycle of a bus access.
	logic [31:0] rd_data;

	assign access = wb_req.cyc && wb_req.stb && !ack;

	// read mux over configuration and status words.
	always_comb begin
		case (wb_req.adr)
			`PING_REG_MAC_DST_LO: rd_data = cfg.mac_dst[31:0];
			`PING_REG_MAC_DST_HI: rd_data = {16'h0000, cfg.mac_dst[47:32]};
			`PING_REG_MAC_SRC_LO: rd_data = cfg.mac_src[31:0];
			`PING_REG_MAC_SRC_HI: rd_data = {16'h0000, cfg.mac_src[47:32]};
			`PING_REG_IP_SRC: rd_data = cfg.ip_src;
			`PING_REG_IP_DST: rd_data = cfg.ip_dst;
			`PING_REG_IDS: rd_data = {cfg.frame_id, cfg.log_id};
			`PING_REG_MODE: rd_data = {31'd0, cfg.reply_mode};
			`PING_REG_PING_ID: rd_data = {16'h0000, ping_id};
			`PING_REG_MATCHED: rd_data = {16'h0000, matched_count};
			`PING_REG_REJECTED: rd_data = {16'h0000, rejected_count};
			default: rd_data = 32'h0000_0000; // unmapped.
		endcase
	end

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			ack <= 1'b0;
			cfg <= '0;
		end else begin
			ack <= access; // one cycle, then low again.
			if (access && wb_req.we) begin
				case (wb_req.adr)
					`PING_REG_MAC_DST_LO: begin
						cfg.mac_dst[31:0] <= wb_req.dat_w;
					end
					`PING_REG_MAC_DST_HI: begin
						cfg.mac_dst[47:32] <= wb_req.dat_w[15:0];
					end
					`PING_REG_MAC_SRC_LO: begin
						cfg.mac_src[31:0] <= wb_req.dat_w;
					end
					`PING_REG_MAC_SRC_HI: begin
						cfg.mac_src[47:32] <= wb_req.dat_w[15:0];
					end
					`PING_REG_IP_SRC: begin
						cfg.ip_src <= wb_req.dat_w;
					end
					`PING_REG_IP_DST: begin
						cfg.ip_dst <= wb_req.dat_w;
					end
					`PING_REG_IDS: begin
						cfg.frame_id <= wb_req.dat_w[31:16];
						cfg.log_id <= wb_req.dat_w[15:0];
					end
					`PING_REG_MODE: begin
						cfg.reply_mode <= wb_req.dat_w[0];
					end
					default: begin
						// status and unmapped words ignore writes.
					end
				endcase
			end
		end
	end

	// read data sampled with the ack edge, held while ack is high.
	always_ff @(posedge clk_rx) begin
		if (access) begin
			dat_r <= rd_data;
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat_r = dat_r;

endmodule

// ==== hdl/ping_config.svh ====
/* Sizes, byte positions and register word addresses of the ping receiver.
   Included by the package, the register block, the matcher and the testbench. */
`ifndef PING_CONFIG_SVH
`define PING_CONFIG_SVH

`define PING_HDR_BYTES 40 // compared header bytes.

`define PING_SEQ_HI 8'd40 // icmp sequence, high byte.
`define PING_SEQ_LO 8'd41 // icmp sequence, low byte.

`define PING_IP_CSUM 8'd24 // first byte of the ipv4 checksum.
`define PING_ICMP_CSUM 8'd36 // first byte of the icmp checksum.

`define PING_REG_MAC_DST_LO 4'd0
`define PING_REG_MAC_DST_HI 4'd1
`define PING_REG_MAC_SRC_LO 4'd2
`define PING_REG_MAC_SRC_HI 4'd3
`define PING_REG_IP_SRC 4'd4
`define PING_REG_IP_DST 4'd5
`define PING_REG_IDS 4'd6 // frame_id high half, log_id low half.
`define PING_REG_MODE 4'd7
`define PING_REG_PING_ID 4'd8 // read-only.
`define PING_REG_MATCHED 4'd9 // read-only.
`define PING_REG_REJECTED 4'd10 // read-only.

`endif

// ==== hdl/ping_frame_matcher.sv ====
/* Byte-serial compare of received frames against the expected ICMP echo header.
   Pulses a verdict one cycle after last and captures the sequence number on a match. */
`timescale 1ns/1ns
`include "ping_config.svh"

module ping_frame_matcher
	import ping_pkg::*;
(
	input logic clk_rx,
	input logic rst_rx,
	input ping_beat_t rx,
	input ping_cfg_t cfg,
	output logic [15:0] ping_id,
	output logic frame_ok,
	output logic frame_bad
);
	frame_header_u expected; // built from cfg.
	frame_header_u hdr; // shifts one byte per beat.
	logic [7:0] count; // byte index within the frame.
	logic is_valid;
	logic [15:0] seq;
	logic [15:0] seq_now;
	logic csum_byte;
	logic byte_bad;

	always_comb begin
		expected.fields.eth_dst = cfg.mac_dst;
		expected.fields.eth_src = cfg.mac_src;
		expected.fields.ethertype = 16'h0800; // ipv4.
		expected.fields.ver_ihl_tos = 16'h4500;
		expected.fields.total_len = 16'h001C;
		expected.fields.ip_ident = cfg.frame_id;
		expected.fields.flags_frag = 16'h4000; // don't fragment.
		expected.fields.ttl = 8'h40;
		expected.fields.proto = 8'h01; // icmp.
		expected.fields.ip_csum = 16'h0000; // skipped.
		expected.fields.ip_src = cfg.ip_src;
		expected.fields.ip_dst = cfg.ip_dst;
		expected.fields.icmp_type = cfg.reply_mode ? 8'h00 : 8'h08;
		expected.fields.icmp_code = 8'h00;
		expected.fields.icmp_csum = 16'h0000; // skipped.
		expected.fields.icmp_ident = cfg.log_id;
	end

	assign csum_byte = (count == `PING_IP_CSUM) || (count == `PING_IP_CSUM + 8'd1) ||
		(count == `PING_ICMP_CSUM) || (count == `PING_ICMP_CSUM + 8'd1);

	assign byte_bad = (count < 8'(`PING_HDR_BYTES)) && !csum_byte &&
		(rx.data != hdr.bytes[`PING_HDR_BYTES-1]);

	// sequence number including the byte on the bus now.
	always_comb begin
		seq_now = seq;
		if (count == `PING_SEQ_HI) begin
			seq_now[15:8] = rx.data;
		end
		if (count == `PING_SEQ_LO) begin
			seq_now[7:0] = rx.data;
		end
	end

	// reload between frames so back-to-back frames start fresh.
	always_ff @(posedge clk_rx) begin
		if (!rx.valid || rx.last) begin
			hdr <= expected;
		end else begin
			hdr.bytes <= {hdr.bytes[`PING_HDR_BYTES-2:0], 8'h00};
		end
		if (rx.valid) begin
			seq <= seq_now;
		end
	end

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			count <= 8'd0;
			is_valid <= 1'b1;
			frame_ok <= 1'b0;
			frame_bad <= 1'b0;
			ping_id <= 16'hFFFF;
		end else begin
			frame_ok <= 1'b0;
			frame_bad <= 1'b0;
			if (rx.valid && rx.last) begin
				count <= 8'd0;
				is_valid <= 1'b1;
				if (is_valid && !byte_bad && count >= `PING_SEQ_LO) begin
					frame_ok <= 1'b1;
					ping_id <= seq_now;
				end else begin
					frame_bad <= 1'b1; // mismatch or too short.
				end
			end else if (rx.valid) begin
				count <= (count == 8'hFF) ? count : count + 8'd1; // saturates on long frames.
				if (byte_bad) begin
					is_valid <= 1'b0;
				end
			end else begin
				count <= 8'd0; // idle drops a partial frame.
				is_valid <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/ping_pkg.sv ====
/* Shared types of the ping receiver: configuration, stream beat, Wishbone
   request and response, and the expected header with its field and byte views. */
`include "ping_config.svh"

package ping_pkg;

	typedef struct packed {
		logic [47:0] mac_dst;
		logic [47:0] mac_src;
		logic [31:0] ip_src;
		logic [31:0] ip_dst;
		logic [15:0] frame_id; // ipv4 identification.
		logic [15:0] log_id; // icmp identifier.
		logic reply_mode; // 1 expects echo reply.
	} ping_cfg_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
		logic valid;
	} ping_beat_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] adr;
		logic [31:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

	typedef struct packed {
		logic [47:0] eth_dst;
		logic [47:0] eth_src;
		logic [15:0] ethertype;
		logic [15:0] ver_ihl_tos;
		logic [15:0] total_len;
		logic [15:0] ip_ident;
		logic [15:0] flags_frag;
		logic [7:0] ttl;
		logic [7:0] proto;
		logic [15:0] ip_csum;
		logic [31:0] ip_src;
		logic [31:0] ip_dst;
		logic [7:0] icmp_type;
		logic [7:0] icmp_code;
		logic [15:0] icmp_csum;
		logic [15:0] icmp_ident;
	} frame_header_t;

	// bytes[39] is the first byte on the wire.
	typedef union packed {
		frame_header_t fields;
		logic [`PING_HDR_BYTES-1:0][7:0] bytes;
	} frame_header_u;

endpackage

// ==== hdl/ping_rx_stats.sv ====
/* Matched and rejected frame counters, readable by software through the
   register block. Both wrap at 16 bits. */
`timescale 1ns/1ns

module ping_rx_stats (
	input logic clk_rx,
	input logic rst_rx,
	input logic frame_ok,
	input logic frame_bad,
	output logic [15:0] matched_count,
	output logic [15:0] rejected_count
);

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			matched_count <= 16'd0;
			rejected_count <= 16'd0;
		end else begin
			if (frame_ok) begin
				matched_count <= matched_count + 16'd1;
			end
			if (frame_bad) begin
				rejected_count <= rejected_count + 16'd1;
			end
		end
	end

endmodule

// ==== hdl/ping_rx_top.sv ====
/* Ping receiver top. Registers feed the frame matcher, whose verdicts
   drive the counters; ping id and counters read back over Wishbone. */
`timescale 1ns/1ns

module ping_rx_top
	import ping_pkg::*;
(
	input logic clk_rx,
	input logic rst_rx,
	input ping_beat_t rx,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output logic [15:0] ping_id
);
	ping_cfg_t cfg;
	logic frame_ok;
	logic frame_bad;
	logic [15:0] matched_count;
	logic [15:0] rejected_count;

	ping_cfg_regs ping_cfg_regs_inst (
		.clk_rx(clk_rx),
		.rst_rx(rst_rx),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.ping_id(ping_id),
		.matched_count(matched_count),
		.rejected_count(rejected_count),
		.cfg(cfg)
	);

	ping_frame_matcher ping_frame_matcher_inst (
		.clk_rx(clk_rx),
		.rst_rx(rst_rx),
		.rx(rx),
		.cfg(cfg),
		.ping_id(ping_id),
		.frame_ok(frame_ok),
		.frame_bad(frame_bad)
	);

	ping_rx_stats ping_rx_stats_inst (
		.clk_rx(clk_rx),
		.rst_rx(rst_rx),
		.frame_ok(frame_ok),
		.frame_bad(frame_bad),
		.matched_count(matched_count),
		.rejected_count(rejected_count)
	);

endmodule
